/* Bender.yml */
package:
  name: hdc_item_memory

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/hdc_pkg.sv
      - verilog/xorshift.sv
      - verilog/item_memory_gen.sv
      - verilog/stream_ctrl.sv
      - verilog/axil_regs.sv
      - verilog/hdc_top.sv
  - target: test
    include_dirs:
      - verilog
      - test
    files:
      - test/tb_hdc_top.sv

/* list.f */
+incdir+verilog
+incdir+test
verilog/hdc_pkg.sv
verilog/xorshift.sv
verilog/item_memory_gen.sv
verilog/stream_ctrl.sv
verilog/axil_regs.sv
verilog/hdc_top.sv
test/tb_hdc_top.sv

/* test/tb_hdc_tasks.svh */
`ifndef TB_HDC_TASKS_SVH
`define TB_HDC_TASKS_SVH

// ======================================================================
// checking and reference model
// ======================================================================

task automatic check_value(input string name, input logic [`HV_DIM-1:0] got,
                           input logic [`HV_DIM-1:0] exp);
    assert (got === exp) else begin
        error_cnt++;
        $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at first error");
    end
endtask

// xorshift32 with shifts 13 / 17 / 5
function automatic word_t xs_next(input word_t s);
    word_t t;
    t = s ^ (s << 13);
    t = t ^ (t >> 17);
    return t ^ (t << 5);
endfunction

// word j of vector k is successor number k*HV_WORDS + j + 1 of the seed
function automatic hv_t model_vector(input int item);
    word_t s;
    hv_t   v;
    s = `XS_SEED;
    for (int i = 0; i < item * `HV_WORDS; i++) begin
        s = xs_next(s);
    end
    for (int j = 0; j < `HV_WORDS; j++) begin
        s = xs_next(s);
        v[j*`WORD_W +: `WORD_W] = s;
    end
    return v;
endfunction

// ======================================================================
// bus tasks
// ======================================================================

// order 0 sends address and data together, 1 address first, 2 data first
task automatic axil_write(input logic [`AXIL_ADDR_W-1:0] addr, input word_t data,
                          input int order);
    logic aw_done;
    logic w_done;
    logic aw_take;
    logic w_take;
    aw_done = 1'b0;
    w_done  = 1'b0;
    @(posedge AXIS_ACLK);
    s_axi_awaddr <= addr;
    s_axi_wdata  <= data;
    s_axi_wstrb  <= '1;
    if (order != 2) begin
        s_axi_awvalid <= 1'b1;
    end
    if (order != 1) begin
        s_axi_wvalid <= 1'b1;
    end
    while (!(aw_done && w_done)) begin
        @(negedge AXIS_ACLK);
        aw_take = s_axi_awvalid && s_axi_awready;
        w_take  = s_axi_wvalid && s_axi_wready;
        @(posedge AXIS_ACLK);
        if (aw_take) begin
            aw_done = 1'b1;
            s_axi_awvalid <= 1'b0;
        end
        if (w_take) begin
            w_done = 1'b1;
            s_axi_wvalid <= 1'b0;
        end
        // second half follows once the first is taken
        if (aw_done && !w_done) begin
            s_axi_wvalid <= 1'b1;
        end
        if (w_done && !aw_done) begin
            s_axi_awvalid <= 1'b1;
        end
    end
    @(negedge AXIS_ACLK);
    while (!s_axi_bvalid) begin
        @(negedge AXIS_ACLK);
    end
    check_value("s_axi_bresp", s_axi_bresp, 2'b00);
endtask

task automatic axil_read(input logic [`AXIL_ADDR_W-1:0] addr, output word_t data);
    logic ar_take;
    ar_take = 1'b0;
    @(posedge AXIS_ACLK);
    s_axi_araddr  <= addr;
    s_axi_arvalid <= 1'b1;
    while (!ar_take) begin
        @(negedge AXIS_ACLK);
        ar_take = s_axi_arvalid && s_axi_arready;
        @(posedge AXIS_ACLK);
    end
    s_axi_arvalid <= 1'b0;
    @(negedge AXIS_ACLK);
    while (!s_axi_rvalid) begin
        @(negedge AXIS_ACLK);
    end
    check_value("s_axi_rresp", s_axi_rresp, 2'b00);
    data = s_axi_rdata;
endtask

task automatic check_read(input logic [`AXIL_ADDR_W-1:0] addr, input word_t exp,
                          input string reg_name);
    word_t got;
    axil_read(addr, got);
    check_value({"s_axi_rdata from ", reg_name}, got, exp);
endtask

// waits for the beat, keeps TREADY low for stall cycles, then accepts it
task automatic receive_beat(input hv_t expected, input int stall);
    hv_t held;
    @(negedge AXIS_ACLK);
    while (!m_axis_tvalid) begin
        @(negedge AXIS_ACLK);
    end
    held = m_axis_tdata;
    repeat (stall) begin
        @(negedge AXIS_ACLK);
        check_value("m_axis_tvalid", m_axis_tvalid, 1'b1);
        check_value("m_axis_tdata", m_axis_tdata, held);
    end
    @(posedge AXIS_ACLK);
    m_axis_tready <= 1'b1;
    @(negedge AXIS_ACLK);
    check_value("m_axis_tvalid", m_axis_tvalid, 1'b1);
    check_value("m_axis_tdata", m_axis_tdata, expected);
    check_value("m_axis_tlast", m_axis_tlast, 1'b1);
    @(posedge AXIS_ACLK);
    m_axis_tready <= 1'b0;
    @(negedge AXIS_ACLK);
    check_value("m_axis_tvalid", m_axis_tvalid, 1'b0);
endtask

// ======================================================================
// directed tests
// ======================================================================

task automatic reset_state();
    @(negedge AXIS_ACLK);
    check_value("s_axi_awready", s_axi_awready, 1'b0);
    check_value("s_axi_wready", s_axi_wready, 1'b0);
    check_value("s_axi_arready", s_axi_arready, 1'b0);
    check_value("s_axi_bvalid", s_axi_bvalid, 1'b0);
    check_value("s_axi_rvalid", s_axi_rvalid, 1'b0);
    check_value("m_axis_tvalid", m_axis_tvalid, 1'b0);
    check_read(`REG_CTRL, 32'h0, "REG_CTRL");
    check_read(`REG_ITEM_SEL, 32'h0, "REG_ITEM_SEL");
endtask

// no beat while nothing has been captured since reset
task automatic run_before_capture();
    axil_write(`REG_CTRL, 32'h2, 0);
    repeat (4) begin
        @(negedge AXIS_ACLK);
        check_value("m_axis_tvalid", m_axis_tvalid, 1'b0);
    end
    check_read(`REG_CTRL, 32'h2, "REG_CTRL");
    axil_write(`REG_CTRL, 32'h0, 0);
    check_read(`REG_CTRL, 32'h0, "REG_CTRL");
endtask

task automatic register_access();
    word_t val;
    for (int order = 0; order < 3; order++) begin
        val = $urandom_range(MAX_ITEM - 1, 0);
        axil_write(`REG_ITEM_SEL, val, order);
        check_read(`REG_ITEM_SEL, val, "REG_ITEM_SEL");
    end
    // offsets outside the map
    axil_write(12'h010, $urandom(), 0);
    check_read(12'h010, 32'h0, "offset 0x010");
    check_read(12'h008, 32'h0, "offset 0x008");
    check_read(`REG_ITEM_SEL, val, "REG_ITEM_SEL");
    check_read(`REG_CTRL, 32'h0, "REG_CTRL");
endtask

task automatic generate_item(input item_t item);
    word_t ctrl;
    $display("generating item %0d", item);
    axil_write(`REG_ITEM_SEL, word_t'(item), 0);
    axil_write(`REG_CTRL, 32'h1, 0);
    // gen clears by itself once the vector is captured
    ctrl = 32'h1;
    while (ctrl[0]) begin
        axil_read(`REG_CTRL, ctrl);
    end
    check_value("s_axi_rdata from REG_CTRL", ctrl, 32'h0);
    axil_write(`REG_CTRL, 32'h2, 0);
    receive_beat(model_vector(item), 0);
    check_read(`REG_CTRL, 32'h0, "REG_CTRL");
    gen_item = item;
endtask

// the captured vector is sent again several times with stalls
task automatic back_pressure();
    hv_t exp_hv;
    int  stall;
    exp_hv = model_vector(gen_item);
    for (int n = 0; n < 3; n++) begin
        stall = $urandom_range(12, 1);
        axil_write(`REG_CTRL, 32'h2, n);
        receive_beat(exp_hv, stall);
        check_read(`REG_CTRL, 32'h0, "REG_CTRL");
    end
endtask

`endif

/* test/tb_hdc_top.sv */
`timescale 1ns/1ns
`include "hdc_defines.svh"

module tb_hdc_top
    import hdc_pkg::*;
();

    // item 39 needs 322 cycles to generate plus polling and bus traffic
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int MAX_ITEM       = 40;

    logic                    AXIS_ACLK = 1'b0;
    logic                    S_AXI_ARESETN;
    logic [`AXIL_ADDR_W-1:0] s_axi_awaddr;
    logic                    s_axi_awvalid;
    logic                    s_axi_awready;
    word_t                   s_axi_wdata;
    logic [`WORD_W/8-1:0]    s_axi_wstrb;
    logic                    s_axi_wvalid;
    logic                    s_axi_wready;
    logic [1:0]              s_axi_bresp;
    logic                    s_axi_bvalid;
    logic                    s_axi_bready;
    logic [`AXIL_ADDR_W-1:0] s_axi_araddr;
    logic                    s_axi_arvalid;
    logic                    s_axi_arready;
    word_t                   s_axi_rdata;
    logic [1:0]              s_axi_rresp;
    logic                    s_axi_rvalid;
    logic                    s_axi_rready;
    logic                    m_axis_tvalid;
    hv_t                     m_axis_tdata;
    logic                    m_axis_tlast;
    logic                    m_axis_tready;

    int    cycle_cnt = 0;
    int    error_cnt = 0;
    item_t gen_item;

    always #10 AXIS_ACLK = ~AXIS_ACLK;

    hdc_top u_dut (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tready (m_axis_tready)
    );

    `include "tb_hdc_tasks.svh"

    // ======================================================================
    // run limit
    // ======================================================================

    always @(posedge AXIS_ACLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $fatal(1, "run limit reached");
        end
    end

    // ======================================================================
    // test sequence
    // ======================================================================

    initial begin
        void'($urandom(32'h737f_e431));
        S_AXI_ARESETN <= 1'b0;
        s_axi_awaddr  <= '0;
        s_axi_awvalid <= 1'b0;
        s_axi_wdata   <= '0;
        s_axi_wstrb   <= '0;
        s_axi_wvalid  <= 1'b0;
        s_axi_bready  <= 1'b1;
        s_axi_araddr  <= '0;
        s_axi_arvalid <= 1'b0;
        s_axi_rready  <= 1'b1;
        m_axis_tready <= 1'b0;
        repeat (5) @(posedge AXIS_ACLK);
        S_AXI_ARESETN <= 1'b1;

        reset_state();
        run_before_capture();
        register_access();
        generate_item(item_t'(0));
        generate_item(item_t'($urandom_range(MAX_ITEM - 1, 1)));
        back_pressure();

        if (error_cnt == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("SIMULATION FAILED");
            $fatal(1, "%0d checks failed", error_cnt);
        end
    end

endmodule

/* verilog/axil_regs.sv */
`timescale 1ns/1ns
`include "hdc_defines.svh"

module axil_regs
    import hdc_pkg::*;
(
    input  logic                    AXIS_ACLK,
    input  logic                    S_AXI_ARESETN,
    input  logic [`AXIL_ADDR_W-1:0] s_axi_awaddr,
    input  logic                    s_axi_awvalid,
    output logic                    s_axi_awready,
    input  word_t                   s_axi_wdata,
    input  logic [`WORD_W/8-1:0]    s_axi_wstrb,
    input  logic                    s_axi_wvalid,
    output logic                    s_axi_wready,
    output logic [1:0]              s_axi_bresp,
    output logic                    s_axi_bvalid,
    input  logic                    s_axi_bready,
    input  logic [`AXIL_ADDR_W-1:0] s_axi_araddr,
    input  logic                    s_axi_arvalid,
    output logic                    s_axi_arready,
    output word_t                   s_axi_rdata,
    output logic [1:0]              s_axi_rresp,
    output logic                    s_axi_rvalid,
    input  logic                    s_axi_rready,
    input  logic                    gen_done,
    input  logic                    sent,
    output logic                    gen,
    output logic                    run,
    output item_t                   item_sel
);

    axil_state_t               state;
    logic                      bus_rdy;
    logic                      wr_commit;
    logic                      aw_hs;
    logic                      w_hs;
    logic                      ar_hs;
    logic [`AXIL_ADDR_W-1:0]   wr_addr;
    logic [`AXIL_ADDR_W-1:0]   rd_addr;
    logic [`AXIL_ADDR_W-1:0]   wr_off;
    logic [`AXIL_ADDR_W-1:0]   rd_off;
    word_t                     wr_data;
    word_t                     rd_word;

    // ======================================================================
    // bus handshake
    // ======================================================================

    // readies come up one cycle after reset release
    assign s_axi_awready = bus_rdy && (state == s_idle || state == s_data_held);
    assign s_axi_wready  = bus_rdy && (state == s_idle || state == s_addr_held);
    // writes take priority, so no read is offered while a write is pending
    assign s_axi_arready = bus_rdy && state == s_idle && !s_axi_awvalid && !s_axi_wvalid;

    assign s_axi_bvalid = (state == s_write_resp);
    assign s_axi_rvalid = (state == s_read_resp);
    assign s_axi_bresp  = 2'b00;
    assign s_axi_rresp  = 2'b00;

    assign aw_hs = s_axi_awvalid && s_axi_awready;
    assign w_hs  = s_axi_wvalid && s_axi_wready;
    assign ar_hs = s_axi_arvalid && s_axi_arready;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state     <= s_idle;
            bus_rdy   <= 1'b0;
            wr_commit <= 1'b0;
        end else begin
            bus_rdy   <= 1'b1;
            wr_commit <= 1'b0;
            case (state)
                s_idle: begin
                    if (aw_hs && w_hs) begin
                        state     <= s_write_resp;
                        wr_commit <= 1'b1;
                    end else if (aw_hs) begin
                        state <= s_addr_held;
                    end else if (w_hs) begin
                        state <= s_data_held;
                    end else if (ar_hs) begin
                        state <= s_read_fetch;
                    end
                end
                s_addr_held: begin
                    if (w_hs) begin
                        state     <= s_write_resp;
                        wr_commit <= 1'b1;
                    end
                end
                s_data_held: begin
                    if (aw_hs) begin
                        state     <= s_write_resp;
                        wr_commit <= 1'b1;
                    end
                end
                s_write_resp: begin
                    if (s_axi_bready) begin
                        state <= s_idle;
                    end
                end
                s_read_fetch: begin
                    state <= s_read_resp;
                end
                s_read_resp: begin
                    if (s_axi_rready) begin
                        state <= s_idle;
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    // address and data latches
    always_ff @(posedge AXIS_ACLK) begin
        if (aw_hs) begin
            wr_addr <= s_axi_awaddr;
        end
        if (w_hs) begin
            wr_data <= s_axi_wdata;
        end
        if (ar_hs) begin
            rd_addr <= s_axi_araddr;
        end
    end

    // ======================================================================
    // register file
    // ======================================================================

    // word aligned offsets; byte strobes are not honored, registers update whole
    assign wr_off = {wr_addr[`AXIL_ADDR_W-1:2], 2'b00};
    assign rd_off = {rd_addr[`AXIL_ADDR_W-1:2], 2'b00};

    // hardware clears first so a software write in the same cycle wins
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            gen      <= 1'b0;
            run      <= 1'b0;
            item_sel <= '0;
        end else begin
            if (gen_done) begin
                gen <= 1'b0;
            end
            if (sent) begin
                run <= 1'b0;
            end
            if (wr_commit) begin
                case (wr_off)
                    `REG_CTRL:     {run, gen} <= wr_data[1:0];
                    `REG_ITEM_SEL: item_sel <= wr_data[`ITEM_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // unknown offsets read as zero
    always_comb begin
        rd_word = '0;
        case (rd_off)
            `REG_CTRL:     rd_word[1:0] = {run, gen};
            `REG_ITEM_SEL: rd_word[`ITEM_W-1:0] = item_sel;
            default: ;
        endcase
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (state == s_read_fetch) begin
            s_axi_rdata <= rd_word;
        end
    end

endmodule

/* verilog/hdc_defines.svh */
`ifndef HDC_DEFINES_SVH
`define HDC_DEFINES_SVH

// hypervector geometry
`define HV_DIM      256
`define WORD_W      32
`define HV_WORDS    (`HV_DIM / `WORD_W)

// item index width for up to 65536 item vectors
`define ITEM_W      16

// xorshift32 start value
`define XS_SEED     32'h2463_534d

// AXI4-Lite register map in byte offsets
`define AXIL_ADDR_W     12
`define REG_CTRL        12'h000
`define REG_ITEM_SEL    12'h004

`endif

/* verilog/hdc_pkg.sv */
`include "hdc_defines.svh"

package hdc_pkg;

    // one full hypervector
    typedef logic [`HV_DIM-1:0] hv_t;

    // generator output word and bus data word
    typedef logic [`WORD_W-1:0] word_t;

    // item vector index
    typedef logic [`ITEM_W-1:0] item_t;

    // slot of a word inside one hypervector
    typedef logic [$clog2(`HV_WORDS)-1:0] word_idx_t;

    // AXI4-Lite slave states
    typedef enum logic [2:0] {
        s_idle,
        s_addr_held,
        s_data_held,
        s_write_resp,
        s_read_fetch,
        s_read_resp
    } axil_state_t;

endpackage

/* verilog/hdc_top.sv */
`timescale 1ns/1ns
`include "hdc_defines.svh"

module hdc_top
    import hdc_pkg::*;
(
    input  logic                    AXIS_ACLK,
    input  logic                    S_AXI_ARESETN,
    // AXI4-Lite slave
    input  logic [`AXIL_ADDR_W-1:0] s_axi_awaddr,
    input  logic                    s_axi_awvalid,
    output logic                    s_axi_awready,
    input  word_t                   s_axi_wdata,
    input  logic [`WORD_W/8-1:0]    s_axi_wstrb,
    input  logic                    s_axi_wvalid,
    output logic                    s_axi_wready,
    output logic [1:0]              s_axi_bresp,
    output logic                    s_axi_bvalid,
    input  logic                    s_axi_bready,
    input  logic [`AXIL_ADDR_W-1:0] s_axi_araddr,
    input  logic                    s_axi_arvalid,
    output logic                    s_axi_arready,
    output word_t                   s_axi_rdata,
    output logic [1:0]              s_axi_rresp,
    output logic                    s_axi_rvalid,
    input  logic                    s_axi_rready,
    // AXI4-Stream master
    output logic                    m_axis_tvalid,
    output hv_t                     m_axis_tdata,
    output logic                    m_axis_tlast,
    input  logic                    m_axis_tready
);

    logic  gen;
    logic  run;
    logic  gen_done;
    logic  sent;
    logic  hv_valid;
    item_t item_sel;

    axil_regs u_axil_regs (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .gen_done      (gen_done),
        .sent          (sent),
        .gen           (gen),
        .run           (run),
        .item_sel      (item_sel)
    );

    // captured vector goes straight out as TDATA
    item_memory_gen u_item_memory_gen (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen           (gen),
        .item_sel      (item_sel),
        .gen_done      (gen_done),
        .hv_valid      (hv_valid),
        .hv            (m_axis_tdata)
    );

    stream_ctrl u_stream_ctrl (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .run           (run),
        .hv_valid      (hv_valid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .sent          (sent)
    );

endmodule

/* verilog/item_memory_gen.sv */
`timescale 1ns/1ns
`include "hdc_defines.svh"

module item_memory_gen
    import hdc_pkg::*;
(
    input  logic  AXIS_ACLK,
    input  logic  S_AXI_ARESETN,
    input  logic  gen,
    input  item_t item_sel,
    output logic  gen_done,
    output logic  hv_valid,
    output hv_t   hv
);

    word_t     rand_word;
    word_idx_t word_idx;
    item_t     vec_cnt;
    hv_t       hv_asm;
    hv_t       asm_next;
    logic      last_word;
    logic      hit;

    xorshift u_xorshift (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen           (gen),
        .rand_word     (rand_word)
    );

    // ======================================================================
    // word and vector counters
    // ======================================================================

    assign last_word = (word_idx == word_idx_t'(`HV_WORDS - 1));
    assign hit       = gen && last_word && (vec_cnt == item_sel);

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            word_idx <= '0;
            vec_cnt  <= '0;
        end else if (last_word) begin
            word_idx <= '0;
            vec_cnt  <= vec_cnt + 1'b1;
        end else begin
            word_idx <= word_idx + 1'b1;
        end
    end

    // ======================================================================
    // assembly and capture
    // ======================================================================

    // current word dropped into its slot with the lowest word first
    always_comb begin
        asm_next = hv_asm;
        asm_next[word_idx*`WORD_W +: `WORD_W] = rand_word;
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (gen) begin
            hv_asm <= asm_next;
        end
    end

    // selected vector kept until the next capture
    always_ff @(posedge AXIS_ACLK) begin
        if (hit) begin
            hv <= asm_next;
        end
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            hv_valid <= 1'b0;
            gen_done <= 1'b0;
        end else begin
            gen_done <= hit;
            if (hit) begin
                hv_valid <= 1'b1;
            end
        end
    end

endmodule

/* verilog/stream_ctrl.sv */
`timescale 1ns/1ns

module stream_ctrl (
    input  logic AXIS_ACLK,
    input  logic S_AXI_ARESETN,
    input  logic run,
    input  logic hv_valid,
    input  logic m_axis_tready,
    output logic m_axis_tvalid,
    output logic m_axis_tlast,
    output logic sent
);

    // tvalid alone holds the state of waiting for run or holding the beat
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            m_axis_tvalid <= 1'b0;
            sent          <= 1'b0;
        end else begin
            sent <= 1'b0;
            if (m_axis_tvalid) begin
                // beat accepted
                if (m_axis_tready) begin
                    m_axis_tvalid <= 1'b0;
                    sent          <= 1'b1;
                end
            end else if (run && hv_valid && !sent) begin
                // run is still high while its clear is in flight
                m_axis_tvalid <= 1'b1;
            end
        end
    end

    // single beat per vector
    assign m_axis_tlast = m_axis_tvalid;

endmodule

/* verilog/xorshift.sv */
`timescale 1ns/1ns
`include "hdc_defines.svh"

module xorshift
    import hdc_pkg::*;
(
    input  logic  AXIS_ACLK,
    input  logic  S_AXI_ARESETN,
    input  logic  gen,
    output word_t rand_word
);

    word_t xs_state;
    word_t xs_a;
    word_t xs_b;

    // xorshift32 step with shifts 13 / 17 / 5
    always_comb begin
        xs_a      = xs_state ^ (xs_state << 13);
        xs_b      = xs_a ^ (xs_a >> 17);
        rand_word = xs_b ^ (xs_b << 5);
    end

    // seed held while idle, one step per cycle while generating
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            xs_state <= `XS_SEED;
        end else begin
            xs_state <= rand_word;
        end
    end

endmodule
